//--- files.f
+incdir+rtl
rtl/serv_pkg.sv
rtl/serv_state.sv
rtl/serv_decode.sv
rtl/serv_immdec.sv
rtl/serv_alu.sv
rtl/serv_result.sv
rtl/serv_top.sv
sim/serv_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = serv_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = CHECKS FAILED

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test failed"; exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/serv_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "serv_params.svh"

module serv_tb;

   localparam int          NUM_INSTR    = 300;
   localparam int          MAX_DELAY    = 5;
   localparam int          INSTR_CYCLES = 34;
   localparam int          RESET_CYCLES = 16;
   localparam int          CLK_PERIOD   = 10;
   localparam int unsigned RAND_SEED    = 32'hbad194bf;
   // Full ack delay plus the ack cycle on every instruction
   localparam int          WATCHDOG_CYCLES =
      NUM_INSTR * (INSTR_CYCLES + MAX_DELAY + 1) + RESET_CYCLES + 200;

   logic                    clk;
   logic                    reset;
   logic                    ibus_ack;
   logic [31:0]             ibus_rdt;
   logic                    rdata0;
   logic                    rdata1;
   logic                    ibus_cyc;
   logic [31:0]             ibus_adr;
   logic                    rf_en;
   logic [4:0]              rf_cnt;
   logic [`SERV_REG_AW-1:0] rreg0;
   logic [`SERV_REG_AW-1:0] rreg1;
   logic                    wen;
   logic                    wdata;
   logic [`SERV_REG_AW-1:0] wreg;

   logic [31:0]             rf_mem [32];
   logic [31:0]             model_regs [32];
   logic [31:0]             pc_model;
   logic                    pend_wen;
   logic [`SERV_REG_AW-1:0] pend_reg;
   logic [4:0]              pend_bit;
   logic                    pend_data;
   int                      value_errs = 0;
   int                      flow_errs  = 0;

   serv_top dut_i (
      .clk        (clk),
      .i_reset    (reset),
      .i_ibus_ack (ibus_ack),
      .i_ibus_rdt (ibus_rdt),
      .i_rdata0   (rdata0),
      .i_rdata1   (rdata1),
      .o_ibus_cyc (ibus_cyc),
      .o_ibus_adr (ibus_adr),
      .o_rf_en    (rf_en),
      .o_rf_cnt   (rf_cnt),
      .o_rreg0    (rreg0),
      .o_rreg1    (rreg1),
      .o_wen      (wen),
      .o_wdata    (wdata),
      .o_wreg     (wreg)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // Serial register file, x0 reads as zero
   assign rdata0 = (rreg0 == '0) ? 1'b0 : rf_mem[rreg0][rf_cnt];
   assign rdata1 = (rreg1 == '0) ? 1'b0 : rf_mem[rreg1][rf_cnt];

   always @(posedge clk) begin
      if (reset) begin
         rf_mem <= '{default: '0};
      end else if (pend_wen) begin
         rf_mem[pend_reg][pend_bit] <= pend_data;
      end
   end

   task automatic next_cycle();
      @(negedge clk);
      // Write port seen mid-cycle, applied at the next rising edge
      pend_wen  = wen;
      pend_reg  = wreg;
      pend_bit  = rf_cnt;
      pend_data = wdata;
   endtask

   task automatic flag_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      value_errs++;
      $display("ERR %s got 0x%08h expected 0x%08h at %0t ns", name, got, exp, $time);
   endtask

   task automatic protocol_fault(input string what);
      flow_errs++;
      $display("Protocol error at %0t ns: %s", $time, what);
   endtask

   task automatic print_summary();
      $display("Summary: %0d value errors, %0d protocol errors", value_errs, flow_errs);
   endtask

   function automatic logic is_kept(input logic [31:0] ins);
      return (ins[6:0] == serv_pkg::OP_IMM) || (ins[6:0] == serv_pkg::OP) ||
             (ins[6:0] == serv_pkg::LUI);
   endfunction

   function automatic logic [31:0] random_instr();
      int unsigned kind;
      logic [6:0]  opc;
      logic [6:0]  f7;
      logic [2:0]  f3;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [31:0] ins;
      kind = $urandom_range(9, 0);
      rd   = 5'($urandom);
      rs1  = 5'($urandom);
      rs2  = 5'($urandom);
      case ($urandom_range(3, 0))
         0:       f3 = serv_pkg::F3_ADD;
         1:       f3 = serv_pkg::F3_XOR;
         2:       f3 = serv_pkg::F3_OR;
         default: f3 = serv_pkg::F3_AND;
      endcase
      if (kind == 0) begin
         // Roughly one in ten is an opcode the core does not execute
         opc = 7'($urandom);
         while (is_kept({25'd0, opc})) begin
            opc = 7'($urandom);
         end
         ins = {25'($urandom), opc};
      end else if (kind <= 4) begin
         opc = serv_pkg::OP_IMM;
         ins = {12'($urandom), rs1, f3, rd, opc};
      end else if (kind <= 7) begin
         opc = serv_pkg::OP;
         f7  = (f3 == 3'b000 && $urandom_range(1, 0) != 0) ? 7'h20 : 7'h00;
         ins = {f7, rs2, rs1, f3, rd, opc};
      end else begin
         opc = serv_pkg::LUI;
         ins = {20'($urandom), rd, opc};
      end
      return ins;
   endfunction

   // RV32I reference result for the kept instructions
   function automatic logic [31:0] isa_result(input logic [31:0] ins);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      a = model_regs[ins[19:15]];
      b = model_regs[ins[24:20]];
      if (ins[6:0] == serv_pkg::OP_IMM) b = {{20{ins[31]}}, ins[31:20]};
      case (ins[14:12])
         3'b000:  res = (ins[6:0] == serv_pkg::OP && ins[30]) ? a - b : a + b;
         3'b100:  res = a ^ b;
         3'b110:  res = a | b;
         3'b111:  res = a & b;
         default: res = '0;
      endcase
      if (ins[6:0] == serv_pkg::LUI) res = {ins[31:12], 12'd0};
      return res;
   endfunction

   task automatic run_instr(input logic [31:0] ins);
      int unsigned delay;
      int          cycles;
      logic [5:0]  bit_idx;
      logic        kept;
      logic        exp_wen;
      logic [4:0]  rd;
      logic [31:0] exp_res;
      logic [31:0] got_res;
      delay   = $urandom_range(MAX_DELAY, 0);
      kept    = is_kept(ins);
      rd      = ins[11:7];
      exp_wen = kept && (rd != 5'd0);
      exp_res = isa_result(ins);
      got_res = '0;
      if (!ibus_cyc) protocol_fault("no fetch request at the start of an instruction");
      if (ibus_adr !== pc_model) flag_mismatch("o_ibus_adr", ibus_adr, pc_model);
      for (int unsigned d = 0; d < delay; d++) begin
         ibus_ack = 1'b0;
         ibus_rdt = $urandom;
         next_cycle();
         if (!ibus_cyc) protocol_fault("fetch request dropped before the ack");
         if (ibus_adr !== pc_model) flag_mismatch("o_ibus_adr", ibus_adr, pc_model);
      end
      ibus_ack = 1'b1;
      ibus_rdt = ins;
      next_cycle();
      ibus_ack = 1'b0;
      ibus_rdt = $urandom;
      cycles   = 1;
      bit_idx  = '0;
      while (!ibus_cyc && cycles < INSTR_CYCLES + 8) begin
         if (rf_en) begin
            if (rf_cnt !== bit_idx[4:0]) flag_mismatch("o_rf_cnt", 32'(rf_cnt), 32'(bit_idx));
            if (wen !== exp_wen) flag_mismatch("o_wen", 32'(wen), 32'(exp_wen));
            if (kept && wreg !== rd) flag_mismatch("o_wreg", 32'(wreg), 32'(rd));
            if (bit_idx < 6'd32) got_res[bit_idx[4:0]] = wdata;
            bit_idx = bit_idx + 6'd1;
         end else if (wen) begin
            protocol_fault("write enable high outside the execute phase");
         end
         if (wen && wreg == '0) protocol_fault("write enable raised for x0");
         next_cycle();
         cycles++;
      end
      if (cycles != INSTR_CYCLES) begin
         protocol_fault($sformatf("next fetch %0d cycles after the ack instead of %0d",
                                  cycles, INSTR_CYCLES));
      end
      if (ibus_cyc && rf_en) protocol_fault("fetch request while the register port is on");
      if (bit_idx != 6'd32) protocol_fault($sformatf("%0d execute cycles, not 32", bit_idx));
      if (kept && got_res !== exp_res) flag_mismatch("o_wdata", got_res, exp_res);
      if (exp_wen) model_regs[rd] = exp_res;
      pc_model = pc_model + 32'd4;
   endtask

   task automatic compare_regfile();
      for (int r = 0; r < 32; r++) begin
         if (rf_mem[5'(r)] !== model_regs[5'(r)]) begin
            flag_mismatch($sformatf("rf[%0d]", r), rf_mem[5'(r)], model_regs[5'(r)]);
         end
      end
   endtask

   initial begin
      void'($urandom(RAND_SEED));
      reset      = 1'b1;
      ibus_ack   = 1'b0;
      ibus_rdt   = '0;
      pend_wen   = 1'b0;
      pend_reg   = '0;
      pend_bit   = '0;
      pend_data  = 1'b0;
      pc_model   = `SERV_RESET_PC;
      model_regs = '{default: '0};
      repeat (RESET_CYCLES) next_cycle();
      reset = 1'b0;
      next_cycle();
      if (!ibus_cyc) protocol_fault("no fetch request after reset");
      if (ibus_adr !== `SERV_RESET_PC) flag_mismatch("o_ibus_adr", ibus_adr, `SERV_RESET_PC);
      if (wen !== 1'b0) flag_mismatch("o_wen", 32'(wen), 32'd0);
      for (int n = 0; n < NUM_INSTR; n++) begin
         run_instr(random_instr());
      end
      compare_regfile();
      print_summary();
      if (value_errs == 0 && flow_errs == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired before all instructions retired");
      print_summary();
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/serv_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "serv_params.svh"

module serv_top (
   input  wire                     clk,
   input  wire                     i_reset,
   input  wire                     i_ibus_ack,
   input  wire [31:0]              i_ibus_rdt,
   input  wire                     i_rdata0,
   input  wire                     i_rdata1,
   output logic                    o_ibus_cyc,
   output logic [31:0]             o_ibus_adr,
   output logic                    o_rf_en,
   output logic [4:0]              o_rf_cnt,
   output logic [`SERV_REG_AW-1:0] o_rreg0,
   output logic [`SERV_REG_AW-1:0] o_rreg1,
   output logic                    o_wen,
   output logic                    o_wdata,
   output logic [`SERV_REG_AW-1:0] o_wreg
);

   logic                    init;
   logic                    cnt_en;
   logic                    cnt0;
   logic [4:0]              cnt;
   logic [`SERV_REG_AW-1:0] rd_addr;
   logic                    sub;
   logic                    op_b_imm;
   logic                    rd_write;
   logic                    utype;
   serv_pkg::alu_sel_e      bool_sel;
   logic                    imm_bit;
   logic                    alu_bit;

   // Register file follows the bit counter
   assign o_rf_en  = cnt_en;
   assign o_rf_cnt = cnt;

   serv_state state (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_ack (i_ibus_ack),
      .o_ibus_cyc (o_ibus_cyc),
      .o_init     (init),
      .o_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_cnt      (cnt)
   );

   // Word is taken only from an ack inside a bus cycle
   serv_decode decode (
      .clk        (clk),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack && o_ibus_cyc),
      .o_rs1_addr (o_rreg0),
      .o_rs2_addr (o_rreg1),
      .o_rd_addr  (rd_addr),
      .o_sub      (sub),
      .o_op_b_imm (op_b_imm),
      .o_rd_write (rd_write),
      .o_utype    (utype),
      .o_bool_sel (bool_sel)
   );

   serv_immdec immdec (
      .clk        (clk),
      .i_init     (init),
      .i_cnt_en   (cnt_en),
      .i_utype    (utype),
      .i_ibus_rdt (i_ibus_rdt),
      .o_imm      (imm_bit)
   );

   serv_alu alu (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_cnt0     (cnt0),
      .i_rs1      (i_rdata0),
      .i_rs2      (i_rdata1),
      .i_imm      (imm_bit),
      .i_op_b_imm (op_b_imm),
      .i_sub      (sub),
      .i_bool_sel (bool_sel),
      .o_rd       (alu_bit)
   );

   serv_result result (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_init     (init),
      .i_cnt_en   (cnt_en),
      .i_cnt0     (cnt0),
      .i_alu_rd   (alu_bit),
      .i_rd_write (rd_write),
      .i_rd_addr  (rd_addr),
      .o_wen      (o_wen),
      .o_wdata    (o_wdata),
      .o_wreg     (o_wreg),
      .o_ibus_adr (o_ibus_adr)
   );

endmodule

`default_nettype wire

//--- rtl/serv_result.sv
`timescale 1ns/100ps
`default_nettype none

`include "serv_params.svh"

module serv_result (
   input  wire                     clk,
   input  wire                     i_reset,
   input  wire                     i_init,
   input  wire                     i_cnt_en,
   input  wire                     i_cnt0,
   input  wire                     i_alu_rd,
   input  wire                     i_rd_write,
   input  wire [`SERV_REG_AW-1:0]  i_rd_addr,
   output logic                    o_wen,
   output logic                    o_wdata,
   output logic [`SERV_REG_AW-1:0] o_wreg,
   output logic [31:0]             o_ibus_adr
);

   logic [31:0] pc;
   logic        pc_carry;
   logic [1:0]  cnt0_dly;
   logic        pc_add;
   logic        pc_sum;
   logic        pc_cout;

   // x0 is never written
   assign o_wen   = i_cnt_en && i_rd_write && (i_rd_addr != '0);
   assign o_wdata = i_alu_rd;
   assign o_wreg  = i_rd_addr;

   // The 4 of PC+4 enters at bit 2, two cycles after cnt0
   assign pc_add  = cnt0_dly[1];
   assign pc_sum  = pc[0] ^ pc_add ^ pc_carry;
   assign pc_cout = (pc[0] & pc_add) | (pc[0] & pc_carry) | (pc_add & pc_carry);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         pc       <= `SERV_RESET_PC;
         pc_carry <= 1'b0;
         cnt0_dly <= 2'b00;
      end else begin
         cnt0_dly <= {cnt0_dly[0], i_cnt0};
         if (i_init) begin
            pc_carry <= 1'b0;
         end else if (i_cnt_en) begin
            pc_carry <= pc_cout;
            pc       <= {pc_sum, pc[31:1]};
         end
      end
   end

   assign o_ibus_adr = pc;

   // Writes start at bit 0 of a burst, never to x0
   assert property (@(posedge clk) disable iff (i_reset)
      $rose(o_wen) |-> (o_wreg != '0) && i_cnt0);

endmodule

`default_nettype wire

//--- rtl/serv_alu.sv
`timescale 1ns/100ps
`default_nettype none

module serv_alu (
   input  wire                clk,
   input  wire                i_cnt_en,
   input  wire                i_cnt0,
   input  wire                i_rs1,
   input  wire                i_rs2,
   input  wire                i_imm,
   input  wire                i_op_b_imm,
   input  wire                i_sub,
   input  wire serv_pkg::alu_sel_e i_bool_sel,
   output logic               o_rd
);

   logic op_b;
   logic add_b;
   logic carry_r;
   logic carry_in;
   logic sum;
   logic carry_out;

   assign op_b = i_op_b_imm ? i_imm : i_rs2;

   // Two's complement subtract, inverted B and carry of one at bit 0
   assign add_b    = op_b ^ i_sub;
   assign carry_in = i_cnt0 ? i_sub : carry_r;

   assign sum       = i_rs1 ^ add_b ^ carry_in;
   assign carry_out = (i_rs1 & add_b) | (i_rs1 & carry_in) | (add_b & carry_in);

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_r <= carry_out;
      end
   end

   always_comb begin
      case (i_bool_sel)
         serv_pkg::ALU_XOR: o_rd = i_rs1 ^ op_b;
         serv_pkg::ALU_OR:  o_rd = i_rs1 | op_b;
         serv_pkg::ALU_AND: o_rd = i_rs1 & op_b;
         default:           o_rd = sum;
      endcase
   end

   // Decoder only subtracts register operands
   assert property (@(posedge clk)
      i_cnt_en |-> !(i_sub && i_op_b_imm));

endmodule

`default_nettype wire

//--- rtl/serv_immdec.sv
`timescale 1ns/100ps
`default_nettype none

module serv_immdec (
   input  wire        clk,
   input  wire        i_init,
   input  wire        i_cnt_en,
   input  wire        i_utype,
   input  wire [31:0] i_ibus_rdt,
   output logic       o_imm
);

   serv_pkg::instr_u shreg;

   logic [31:0] imm_i;
   logic [31:0] imm_u;

   // Both views of the word held since the ack cycle
   assign imm_i = {{20{shreg.iu.imm[11]}}, shreg.iu.imm};
   assign imm_u = {shreg.iu.imm, shreg.iu.rs1, shreg.iu.funct3, 12'd0};

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         shreg <= {1'b0, shreg[31:1]};
      end else if (i_init) begin
         shreg <= i_utype ? imm_u : imm_i;
      end else begin
         // Fetch phase, the last word loaded is the acked one
         shreg <= i_ibus_rdt;
      end
   end

   assign o_imm = shreg[0];

endmodule

`default_nettype wire

//--- rtl/serv_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "serv_params.svh"

module serv_decode (
   input  wire                     clk,
   input  wire [31:0]              i_ibus_rdt,
   input  wire                     i_ibus_ack,
   output logic [`SERV_REG_AW-1:0] o_rs1_addr,
   output logic [`SERV_REG_AW-1:0] o_rs2_addr,
   output logic [`SERV_REG_AW-1:0] o_rd_addr,
   output logic                    o_sub,
   output logic                    o_op_b_imm,
   output logic                    o_rd_write,
   output logic                    o_utype,
   output serv_pkg::alu_sel_e      o_bool_sel
);

   serv_pkg::instr_u instr;

   logic is_op_imm;
   logic is_op;
   logic is_lui;
   logic f3_known;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         instr <= i_ibus_rdt;
      end
   end

   assign is_op_imm = (instr.r.opcode == serv_pkg::OP_IMM);
   assign is_op     = (instr.r.opcode == serv_pkg::OP);
   assign is_lui    = (instr.r.opcode == serv_pkg::LUI);

   always_comb begin
      f3_known   = 1'b1;
      o_bool_sel = serv_pkg::ALU_ADD;
      case (instr.r.funct3)
         serv_pkg::F3_ADD: o_bool_sel = serv_pkg::ALU_ADD;
         serv_pkg::F3_XOR: o_bool_sel = serv_pkg::ALU_XOR;
         serv_pkg::F3_OR:  o_bool_sel = serv_pkg::ALU_OR;
         serv_pkg::F3_AND: o_bool_sel = serv_pkg::ALU_AND;
         default:          f3_known   = 1'b0;
      endcase
      // LUI has no funct3, it is x0 plus the immediate
      if (is_lui) begin
         o_bool_sel = serv_pkg::ALU_ADD;
         f3_known   = 1'b1;
      end
   end

   // Bit 30 of the word selects SUB within OP
   assign o_sub = is_op && instr.r.funct7[5] && (instr.r.funct3 == serv_pkg::F3_ADD);

   assign o_op_b_imm = is_op_imm || is_lui;
   assign o_utype    = is_lui;

   // Unknown opcodes and funct3 values retire without a write
   assign o_rd_write = is_lui || ((is_op || is_op_imm) && f3_known);

   assign o_rs1_addr = is_lui ? '0 : instr.r.rs1;
   assign o_rs2_addr = instr.r.rs2;
   assign o_rd_addr  = instr.r.rd;

endmodule

`default_nettype wire

//--- rtl/serv_state.sv
`timescale 1ns/100ps
`default_nettype none

module serv_state (
   input  wire        clk,
   input  wire        i_reset,
   input  wire        i_ibus_ack,
   output logic       o_ibus_cyc,
   output logic       o_init,
   output logic       o_cnt_en,
   output logic       o_cnt0,
   output logic [4:0] o_cnt
);

   logic       cyc_r;
   logic       init_r;
   logic       exec_r;
   logic [4:0] cnt_r;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         cyc_r  <= 1'b1;
         init_r <= 1'b0;
         exec_r <= 1'b0;
         cnt_r  <= 5'd0;
      end else begin
         // Fetch ends in the cycle the ack is seen
         if (cyc_r && i_ibus_ack) begin
            cyc_r  <= 1'b0;
            init_r <= 1'b1;
         end
         if (init_r) begin
            init_r <= 1'b0;
            exec_r <= 1'b1;
         end
         // Counter wraps to zero by itself after bit 31
         if (exec_r) begin
            cnt_r <= cnt_r + 5'd1;
            if (cnt_r == 5'd31) begin
               exec_r <= 1'b0;
               cyc_r  <= 1'b1;
            end
         end
      end
   end

   assign o_ibus_cyc = cyc_r;
   assign o_init     = init_r;
   assign o_cnt_en   = exec_r;
   assign o_cnt0     = exec_r && (cnt_r == 5'd0);
   assign o_cnt      = cnt_r;

   // Bus request and bit-serial execution are exclusive
   assert property (@(posedge clk) disable iff (i_reset)
      !(cyc_r && exec_r));

endmodule

`default_nettype wire

//--- rtl/serv_pkg.sv
`default_nettype none

`include "serv_params.svh"

package serv_pkg;

   // Major opcodes the core executes
   typedef enum logic [6:0] {
      OP_IMM = 7'b0010011,
      OP     = 7'b0110011,
      LUI    = 7'b0110111
   } opcode_e;

   typedef enum logic [2:0] {
      F3_ADD = 3'b000,
      F3_XOR = 3'b100,
      F3_OR  = 3'b110,
      F3_AND = 3'b111
   } funct3_e;

   // ALU output select
   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_XOR,
      ALU_OR,
      ALU_AND
   } alu_sel_e;

   typedef struct packed {
      logic [6:0]              funct7;
      logic [`SERV_REG_AW-1:0] rs2;
      logic [`SERV_REG_AW-1:0] rs1;
      logic [2:0]              funct3;
      logic [`SERV_REG_AW-1:0] rd;
      logic [6:0]              opcode;
   } instr_r_t;

   // Also used for U-type, the upper 20 bits being the immediate
   typedef struct packed {
      logic [11:0]             imm;
      logic [`SERV_REG_AW-1:0] rs1;
      logic [2:0]              funct3;
      logic [`SERV_REG_AW-1:0] rd;
      logic [6:0]              opcode;
   } instr_iu_t;

   typedef union packed {
      instr_r_t  r;
      instr_iu_t iu;
   } instr_u;

endpackage

`default_nettype wire

//--- rtl/serv_params.svh
`ifndef SERV_PARAMS_SVH
`define SERV_PARAMS_SVH

// First fetch address after reset
`define SERV_RESET_PC 32'h0000_0000

// Register address width, 32 registers
`define SERV_REG_AW 5

`endif
